// File: include/lua_cpu_defs.svh
`ifndef LUA_CPU_DEFS_SVH
`define LUA_CPU_DEFS_SVH

// datapath widths
`define LUA_WORD_W 32
`define LUA_REG_CNT 32
`define LUA_REG_IDX_W 5
`define LUA_TTAG_W 5
`define LUA_OPCODE_W 6

// CallInfo layout, savedpc inside the Lua part
`define LUA_CI_SAVEDPC_OFS 32'd20

// stack slot is a TValue, value word then tag word
`define LUA_TVALUE_SHIFT 3
`define LUA_TTAG_OFS 32'd4

`define LUA_INSTR_BYTES 32'd4

// opcodes
`define LUA_OP_MOVE 6'd0

`endif

// File: verilog/lua_cpu_pkg.sv
`include "lua_cpu_defs.svh"

package lua_cpu_pkg;

	typedef logic [`LUA_WORD_W-1:0] word_t;
	typedef logic [`LUA_REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`LUA_TTAG_W-1:0] ttag_t;
	typedef logic [`LUA_OPCODE_W-1:0] opcode_t;

	typedef enum logic [1:0] {
		instr_in_progress = 2'd0,
		instr_done = 2'd1,
		instr_not_impl = 2'd3
	} instr_status_e;

	// who owns register port A
	typedef enum logic [1:0] {
		src_instr = 2'd0,
		src_dumper = 2'd1,
		src_external = 2'd3
	} write_src_e;

	typedef enum logic [1:0] {
		cmd_run = 2'd0,
		cmd_load_reg = 2'd1,
		cmd_load_type = 2'd2,
		cmd_load_base = 2'd3
	} cmd_e;

	typedef enum logic [3:0] {
		ex_idle = 4'd0,
		ex_fetch_pc = 4'd1,
		ex_fetch_instr = 4'd2,
		ex_exec_instr = 4'd3,
		ex_store_pc = 4'd4,
		ex_store_regs = 4'd5,
		ex_load_reg = 4'd6,
		ex_load_type = 4'd7,
		ex_load_base = 4'd8,
		ex_finish = 4'd15
	} ex_state_e;

	typedef enum logic [1:0] {
		dp_idle = 2'd0,
		dp_value = 2'd1,
		dp_type = 2'd2,
		dp_end = 2'd3
	} dump_phase_e;

endpackage

// File: verilog/pc_unit.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module pc_unit (
	input logic clk,
	input logic rst,
	input lua_cpu_pkg::word_t ci,
	input logic fetch_pc,
	input logic store_pc,
	input logic incr_pc,
	input lua_cpu_pkg::word_t mem_readdata,
	input logic mem_waitrequest,
	output lua_cpu_pkg::word_t pc,
	output logic pc_done,
	output lua_cpu_pkg::word_t mem_address,
	output lua_cpu_pkg::word_t mem_writedata,
	output logic mem_read,
	output logic mem_write
);
	import lua_cpu_pkg::*;

	word_t savedpc_addr;
	logic fetch_go;
	logic store_go;

	assign savedpc_addr = ci + `LUA_CI_SAVEDPC_OFS;
	assign fetch_go = fetch_pc && !pc_done;	// request until finished
	assign store_go = store_pc && !pc_done;

	always_comb begin
		mem_address = '0;
		mem_writedata = '0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		if (fetch_go) begin
			mem_address = savedpc_addr;
			mem_read = 1'b1;
		end else if (store_go) begin
			mem_address = savedpc_addr;
			mem_writedata = pc;
			mem_write = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			pc_done <= 1'b0;
		end else begin
			pc_done <= (fetch_go || store_go) && !mem_waitrequest;
			if (fetch_go && !mem_waitrequest)
				pc <= mem_readdata;
			else if (incr_pc)
				pc <= pc + `LUA_INSTR_BYTES;
		end
	end

endmodule

// File: verilog/instr_fetch.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module instr_fetch (
	input logic clk,
	input logic rst,
	input lua_cpu_pkg::word_t pc,
	input logic fetch_instr,
	input lua_cpu_pkg::word_t mem_readdata,
	input logic mem_waitrequest,
	output lua_cpu_pkg::word_t instruction,
	output lua_cpu_pkg::opcode_t opcode,
	output lua_cpu_pkg::reg_idx_t idx_a,
	output lua_cpu_pkg::reg_idx_t idx_b,
	output logic ir_done,
	output lua_cpu_pkg::word_t mem_address,
	output logic mem_read
);
	localparam int a_lsb = 6;	// A field 13:6
	localparam int b_lsb = 14;	// B field 22:14

	logic fetch_go;

	assign fetch_go = fetch_instr && !ir_done;
	assign mem_read = fetch_go;
	assign mem_address = fetch_go ? pc : '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instruction <= '0;
			ir_done <= 1'b0;
		end else begin
			ir_done <= fetch_go && !mem_waitrequest;
			if (fetch_go && !mem_waitrequest)
				instruction <= mem_readdata;
		end
	end

	// only the window part of A and B is used
	assign opcode = instruction[`LUA_OPCODE_W-1:0];
	assign idx_a = instruction[a_lsb +: `LUA_REG_IDX_W];
	assign idx_b = instruction[b_lsb +: `LUA_REG_IDX_W];

endmodule

// File: verilog/instr_exec.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module instr_exec (
	input logic clk,
	input logic rst,
	input logic run_instr,
	input lua_cpu_pkg::opcode_t opcode,
	input lua_cpu_pkg::word_t data_b,
	input lua_cpu_pkg::ttag_t type_b,
	output lua_cpu_pkg::word_t exec_data,
	output lua_cpu_pkg::ttag_t exec_type,
	output logic exec_we,
	output lua_cpu_pkg::instr_status_e instr_status
);
	import lua_cpu_pkg::*;

	logic is_move;

	assign is_move = (opcode == `LUA_OP_MOVE);

	always_comb begin
		exec_data = '0;
		exec_type = '0;
		exec_we = 1'b0;
		if (run_instr && is_move) begin
			exec_data = data_b;	// R(A) := R(B)
			exec_type = type_b;
			exec_we = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			instr_status <= instr_in_progress;
		else if (run_instr)
			instr_status <= is_move ? instr_done : instr_not_impl;
		else
			instr_status <= instr_in_progress;
	end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module register_file (
	input logic clk,
	input logic rst,
	input lua_cpu_pkg::write_src_e write_src,
	input lua_cpu_pkg::reg_idx_t idx_a,
	input lua_cpu_pkg::reg_idx_t idx_b,
	input lua_cpu_pkg::reg_idx_t dump_idx,
	input lua_cpu_pkg::word_t slot_addr,
	input lua_cpu_pkg::word_t ext_data,
	input lua_cpu_pkg::word_t exec_data,
	input lua_cpu_pkg::ttag_t exec_type,
	input logic exec_we,
	input logic load_value,
	input logic load_type,
	input logic load_base,
	input logic clear_dirty,
	output lua_cpu_pkg::word_t data_a,
	output lua_cpu_pkg::ttag_t type_a,
	output logic dirty_a,
	output logic valid_a,
	output lua_cpu_pkg::word_t data_b,
	output lua_cpu_pkg::ttag_t type_b,
	output lua_cpu_pkg::word_t base,
	output logic global_dirty
);
	import lua_cpu_pkg::*;

	word_t values [`LUA_REG_CNT];
	ttag_t tags [`LUA_REG_CNT];
	logic [`LUA_REG_CNT-1:0] dirty;
	logic [`LUA_REG_CNT-1:0] valid;

	word_t slot_ofs;
	logic in_window;
	logic external;
	reg_idx_t wr_idx;
	word_t wr_data;
	ttag_t wr_type;
	logic we_value;
	logic we_type;

	always_comb begin
		slot_ofs = (slot_addr - base) >> `LUA_TVALUE_SHIFT;	// stack slot number
		in_window = (slot_ofs < `LUA_REG_CNT);
		external = (write_src == src_external);
		case (write_src)
			src_dumper: wr_idx = dump_idx;
			src_external: wr_idx = slot_ofs[`LUA_REG_IDX_W-1:0];
			default: wr_idx = idx_a;
		endcase
		wr_data = external ? ext_data : exec_data;
		wr_type = external ? ext_data[`LUA_TTAG_W-1:0] : exec_type;
		we_value = external ? (load_value && in_window) : exec_we;
		we_type = external ? (load_type && in_window) : exec_we;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `LUA_REG_CNT; i++) begin
				values[i] <= '0;
				tags[i] <= '0;
			end
			dirty <= '0;
			valid <= '0;
			global_dirty <= 1'b0;
			base <= '0;
		end else begin
			if (clear_dirty) begin
				dirty <= '0;
				global_dirty <= 1'b0;
			end else begin
				if (we_value) begin
					values[wr_idx] <= wr_data;
					valid[wr_idx] <= 1'b1;	// tag write follows if needed
				end
				if (we_type)
					tags[wr_idx] <= wr_type;
				if ((we_value || we_type) && !external) begin
					dirty[wr_idx] <= 1'b1;
					global_dirty <= 1'b1;
				end
			end
			if (load_base)
				base <= slot_addr;
		end
	end

	assign data_a = values[wr_idx];
	assign type_a = tags[wr_idx];
	assign dirty_a = dirty[wr_idx];
	assign valid_a = valid[wr_idx];
	assign data_b = values[idx_b];
	assign type_b = tags[idx_b];

endmodule

// File: verilog/register_dumper.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module register_dumper (
	input logic clk,
	input logic rst,
	input logic store_regs,
	input lua_cpu_pkg::word_t base,
	input lua_cpu_pkg::word_t data_a,
	input lua_cpu_pkg::ttag_t type_a,
	input logic dirty_a,
	input logic valid_a,
	input logic mem_waitrequest,
	output lua_cpu_pkg::reg_idx_t dump_idx,
	output logic dump_done,
	output lua_cpu_pkg::word_t mem_address,
	output lua_cpu_pkg::word_t mem_writedata,
	output logic mem_write
);
	import lua_cpu_pkg::*;

	dump_phase_e phase;
	reg_idx_t cur_reg;
	word_t slot_base;
	logic should_write;
	logic last_reg;
	logic step;

	assign dump_idx = cur_reg;
	assign dump_done = (phase == dp_end);
	assign should_write = dirty_a && valid_a;
	assign last_reg = (cur_reg == reg_idx_t'(`LUA_REG_CNT - 1));
	assign step = !should_write || !mem_waitrequest;	// clean regs pass in one cycle
	assign slot_base = base + (word_t'(cur_reg) << `LUA_TVALUE_SHIFT);

	always_comb begin
		mem_address = '0;
		mem_writedata = '0;
		mem_write = 1'b0;
		if (phase == dp_value && should_write) begin
			mem_address = slot_base;
			mem_writedata = data_a;
			mem_write = 1'b1;
		end else if (phase == dp_type && should_write) begin
			mem_address = slot_base + `LUA_TTAG_OFS;
			mem_writedata = word_t'(type_a);
			mem_write = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= dp_idle;
			cur_reg <= '0;
		end else begin
			case (phase)
				dp_idle: begin
					if (store_regs) begin
						cur_reg <= '0;
						phase <= dp_value;
					end
				end
				dp_value: begin
					if (step) begin
						if (should_write)
							phase <= dp_type;
						else if (last_reg)
							phase <= dp_end;
						else
							cur_reg <= cur_reg + 1'b1;
					end
				end
				dp_type: begin
					if (!mem_waitrequest) begin
						phase <= last_reg ? dp_end : dp_value;
						cur_reg <= cur_reg + 1'b1;
					end
				end
				default: phase <= dp_idle;
			endcase
		end
	end

endmodule

// File: verilog/main_sequencer.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module main_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input lua_cpu_pkg::cmd_e n,
	input logic pc_done,
	input logic ir_done,
	input logic dump_done,
	input lua_cpu_pkg::instr_status_e instr_status,
	input logic global_dirty,
	output logic fetch_pc,
	output logic store_pc,
	output logic incr_pc,
	output logic fetch_instr,
	output logic run_instr,
	output logic store_regs,
	output logic load_value,
	output logic load_type,
	output logic load_base,
	output lua_cpu_pkg::write_src_e write_src,
	output logic clear_dirty,
	output logic done
);
	import lua_cpu_pkg::*;

	ex_state_e state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ex_idle;
			done <= 1'b0;
		end else begin
			done <= (state == ex_finish);	// host sees done one cycle after finish
			case (state)
				ex_idle: begin
					if (start) begin
						case (n)
							cmd_run: state <= ex_fetch_pc;
							cmd_load_reg: state <= ex_load_reg;
							cmd_load_type: state <= ex_load_type;
							default: state <= ex_load_base;
						endcase
					end
				end
				ex_fetch_pc: if (pc_done) state <= ex_fetch_instr;
				ex_fetch_instr: if (ir_done) state <= ex_exec_instr;
				ex_exec_instr: begin
					if (instr_status == instr_done)
						state <= ex_fetch_instr;
					else if (instr_status == instr_not_impl)
						state <= ex_store_pc;
				end
				ex_store_pc: begin
					if (pc_done)
						state <= global_dirty ? ex_store_regs : ex_finish;
				end
				ex_store_regs: if (dump_done) state <= ex_finish;
				ex_finish: state <= ex_idle;
				default: state <= ex_finish;	// single-cycle loads
			endcase
		end
	end

	always_comb begin
		fetch_pc = (state == ex_fetch_pc);
		store_pc = (state == ex_store_pc);
		fetch_instr = (state == ex_fetch_instr);
		incr_pc = fetch_instr && ir_done;
		run_instr = (state == ex_exec_instr);
		store_regs = (state == ex_store_regs);
		load_value = (state == ex_load_reg);
		load_type = (state == ex_load_type);
		load_base = (state == ex_load_base);
		clear_dirty = (state == ex_finish);
		if (load_value || load_type)
			write_src = src_external;
		else if (store_regs)
			write_src = src_dumper;
		else
			write_src = src_instr;
	end

endmodule

// File: verilog/lua_cpu.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module lua_cpu (
	input logic clk,
	input logic rst,
	input logic start,
	input lua_cpu_pkg::cmd_e n,
	input lua_cpu_pkg::word_t dataa,
	input lua_cpu_pkg::word_t datab,
	output logic done,
	output lua_cpu_pkg::word_t result,
	output lua_cpu_pkg::word_t mem_address,
	output lua_cpu_pkg::word_t mem_writedata,
	output logic mem_read,
	output logic mem_write,
	input lua_cpu_pkg::word_t mem_readdata,
	input logic mem_waitrequest
);
	import lua_cpu_pkg::*;

	logic fetch_pc, store_pc, incr_pc, fetch_instr, run_instr, store_regs;
	logic load_value, load_type, load_base, clear_dirty;
	write_src_e write_src;
	logic pc_done, ir_done, dump_done, global_dirty;
	instr_status_e instr_status;

	word_t pc, instruction, base;
	opcode_t opcode;
	reg_idx_t idx_a, idx_b, dump_idx;
	word_t data_a, data_b, exec_data;
	ttag_t type_a, type_b, exec_type;
	logic dirty_a, valid_a, exec_we;

	word_t pc_mem_address, pc_mem_writedata, if_mem_address;
	word_t dump_mem_address, dump_mem_writedata;
	logic pc_mem_read, pc_mem_write, if_mem_read, dump_mem_write;

	main_sequencer u_seq (
		.clk(clk), .rst(rst), .start(start), .n(n),
		.pc_done(pc_done), .ir_done(ir_done), .dump_done(dump_done),
		.instr_status(instr_status), .global_dirty(global_dirty),
		.fetch_pc(fetch_pc), .store_pc(store_pc), .incr_pc(incr_pc),
		.fetch_instr(fetch_instr), .run_instr(run_instr), .store_regs(store_regs),
		.load_value(load_value), .load_type(load_type), .load_base(load_base),
		.write_src(write_src), .clear_dirty(clear_dirty), .done(done)
	);

	pc_unit u_pc (
		.clk(clk), .rst(rst), .ci(dataa),
		.fetch_pc(fetch_pc), .store_pc(store_pc), .incr_pc(incr_pc),
		.mem_readdata(mem_readdata), .mem_waitrequest(mem_waitrequest),
		.pc(pc), .pc_done(pc_done),
		.mem_address(pc_mem_address), .mem_writedata(pc_mem_writedata),
		.mem_read(pc_mem_read), .mem_write(pc_mem_write)
	);

	instr_fetch u_fetch (
		.clk(clk), .rst(rst), .pc(pc), .fetch_instr(fetch_instr),
		.mem_readdata(mem_readdata), .mem_waitrequest(mem_waitrequest),
		.instruction(instruction), .opcode(opcode), .idx_a(idx_a), .idx_b(idx_b),
		.ir_done(ir_done), .mem_address(if_mem_address), .mem_read(if_mem_read)
	);

	instr_exec u_exec (
		.clk(clk), .rst(rst), .run_instr(run_instr), .opcode(opcode),
		.data_b(data_b), .type_b(type_b),
		.exec_data(exec_data), .exec_type(exec_type), .exec_we(exec_we),
		.instr_status(instr_status)
	);

	register_file u_rf (
		.clk(clk), .rst(rst), .write_src(write_src),
		.idx_a(idx_a), .idx_b(idx_b), .dump_idx(dump_idx),
		.slot_addr(dataa), .ext_data(datab),
		.exec_data(exec_data), .exec_type(exec_type), .exec_we(exec_we),
		.load_value(load_value), .load_type(load_type), .load_base(load_base),
		.clear_dirty(clear_dirty),
		.data_a(data_a), .type_a(type_a), .dirty_a(dirty_a), .valid_a(valid_a),
		.data_b(data_b), .type_b(type_b), .base(base), .global_dirty(global_dirty)
	);

	register_dumper u_dump (
		.clk(clk), .rst(rst), .store_regs(store_regs), .base(base),
		.data_a(data_a), .type_a(type_a), .dirty_a(dirty_a), .valid_a(valid_a),
		.mem_waitrequest(mem_waitrequest),
		.dump_idx(dump_idx), .dump_done(dump_done),
		.mem_address(dump_mem_address), .mem_writedata(dump_mem_writedata),
		.mem_write(dump_mem_write)
	);

	// idle units drive zeros, so OR is the mux
	assign mem_address = if_mem_address | pc_mem_address | dump_mem_address;
	assign mem_writedata = pc_mem_writedata | dump_mem_writedata;
	assign mem_read = if_mem_read | pc_mem_read;
	assign mem_write = pc_mem_write | dump_mem_write;
	assign result = instruction;

endmodule

// File: test/lua_cpu_assert.sv
`timescale 1ns/1ps

module lua_cpu_assert (
	input logic clk,
	input logic rst,
	input logic start,
	input logic done,
	input lua_cpu_pkg::word_t result,
	input lua_cpu_pkg::word_t mem_address,
	input lua_cpu_pkg::word_t mem_writedata,
	input logic mem_read,
	input logic mem_write,
	input logic mem_waitrequest
);
	logic seen_start;
	bit idle_fail = 1'b0;
	bit excl_fail = 1'b0;
	bit hold_fail = 1'b0;
	bit pulse_fail = 1'b0;
	logic [3:0] fail_flags;

	assign fail_flags = {idle_fail, excl_fail, hold_fail, pulse_fail};

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			seen_start <= 1'b0;
		else if (start)
			seen_start <= 1'b1;
	end

	// quiet from reset until the first command
	idle_after_reset: assert property (@(posedge clk) disable iff (rst)
		!seen_start |-> !mem_read && !mem_write && !done && result == '0)
	else begin
		$error("bus request, done or result active before the first start");
		idle_fail = 1'b1;
	end

	read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write))
	else begin
		$error("mem_read and mem_write high in the same cycle");
		excl_fail = 1'b1;
	end

	request_held: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) && mem_waitrequest |=>
			$stable(mem_address) && $stable(mem_writedata)
			&& $stable(mem_read) && $stable(mem_write))
	else begin
		$error("bus request changed while waitrequest was high");
		hold_fail = 1'b1;
	end

	done_single_cycle: assert property (@(posedge clk) disable iff (rst)
		done |=> !done)
	else begin
		$error("done held for more than one cycle");
		pulse_fail = 1'b1;
	end

endmodule

// File: test/lua_cpu_tb.sv
`timescale 1ns/1ps
`include "lua_cpu_defs.svh"

module lua_cpu_tb;
	import lua_cpu_pkg::*;

	localparam int clk_period = 40;
	localparam int reset_cycles = 5;
	localparam int cmd_count = 9;
	localparam int cmd_cycles = 200;	// budget per command
	localparam int mem_words = 1024;

	localparam word_t win_base = 32'h0000_0200;
	localparam word_t ci_first = 32'h0000_0100;
	localparam word_t ci_second = 32'h0000_0140;
	localparam word_t prog_first = 32'h0000_0400;
	localparam word_t prog_second = 32'h0000_0480;
	localparam word_t unimpl_first = 32'h0012_34ca;	// opcode 10
	localparam word_t unimpl_second = 32'h00ab_cd85;	// opcode 5
	localparam word_t r0_value = 32'h1111_2222;
	localparam word_t r0_tag = 32'h0000_0013;
	localparam word_t r5_value = 32'h3333_4444;
	localparam word_t r5_tag = 32'h0000_0004;

	logic clk;
	logic rst;
	logic start;
	cmd_e n;
	word_t dataa;
	word_t datab;
	logic done;
	word_t result;
	word_t mem_address;
	word_t mem_writedata;
	logic mem_read;
	logic mem_write;
	word_t mem_readdata = '0;
	logic mem_waitrequest = 1'b0;

	word_t mem [mem_words];
	word_t wr_addr_q [$];
	word_t wr_data_q [$];
	int errors = 0;

	lua_cpu DUT (
		.clk(clk), .rst(rst), .start(start), .n(n), .dataa(dataa), .datab(datab),
		.done(done), .result(result),
		.mem_address(mem_address), .mem_writedata(mem_writedata),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_readdata(mem_readdata), .mem_waitrequest(mem_waitrequest)
	);

	bind lua_cpu lua_cpu_assert u_assert (
		.clk(clk), .rst(rst), .start(start), .done(done), .result(result),
		.mem_address(mem_address), .mem_writedata(mem_writedata),
		.mem_read(mem_read), .mem_write(mem_write), .mem_waitrequest(mem_waitrequest)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// memory writes land on the accepting edge
	always @(posedge clk) begin
		if (mem_write && !mem_waitrequest) begin
			mem[mem_address[11:2]] = mem_writedata;
			wr_addr_q.push_back(mem_address);
			wr_data_q.push_back(mem_writedata);
		end
	end

	initial begin
		void'($urandom(32'h7ab1f27f));
		forever begin
			@(negedge clk);
			mem_waitrequest <= ($urandom % 3) == 0;
			mem_readdata <= mem[mem_address[11:2]];
		end
	end

	function automatic int word_index(word_t addr);
		return int'(addr[11:2]);
	endfunction

	function automatic word_t encode_move(int a, int b);
		return (word_t'(b) << 14) | (word_t'(a) << 6) | word_t'(`LUA_OP_MOVE);
	endfunction

	function automatic word_t slot_address(word_t base, int idx);
		return base + (word_t'(idx) << `LUA_TVALUE_SHIFT);
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			errors++;
			$display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_write(input int k, input word_t addr, input word_t data);
		assert (k < wr_addr_q.size()) else begin
			errors++;
			$display("memory write number %0d never happened", k);
		end
		if (k < wr_addr_q.size()) begin
			check_word("mem_address", wr_addr_q[k], addr);
			check_word("mem_writedata", wr_data_q[k], data);
		end
	endtask

	// starts on a falling edge, returns on the falling edge that sees done
	task automatic run_command(input cmd_e cmd, input word_t a, input word_t b,
			output int latency);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		n = cmd;
		dataa = a;
		datab = b;
		start = 1'b1;
		@(posedge clk);
		while (!seen && cycles <= cmd_cycles) begin
			@(negedge clk);
			start = 1'b0;
			if (done)
				seen = 1'b1;
			else
				cycles++;
		end
		assert (seen) else begin
			errors++;
			$display("command %s got no done within %0d cycles", cmd.name(), cmd_cycles);
		end
		latency = cycles;
	endtask

	task automatic load_command(input cmd_e cmd, input word_t a, input word_t b);
		int latency;
		run_command(cmd, a, b, latency);
		check_word("done latency", word_t'(latency), 32'd2);
	endtask

	initial begin
		int latency;
		int first;
		int afails;
		rst = 1'b1;
		start = 1'b0;
		n = cmd_run;
		dataa = '0;
		datab = '0;
		for (int i = 0; i < mem_words; i++)
			mem[i] = 32'h5a5a_0000 ^ word_t'(i << 2);
		mem[word_index(ci_first + `LUA_CI_SAVEDPC_OFS)] = prog_first;
		mem[word_index(prog_first)] = encode_move(3, 0);
		mem[word_index(prog_first + `LUA_INSTR_BYTES)] = encode_move(7, 5);
		mem[word_index(prog_first + 2 * `LUA_INSTR_BYTES)] = unimpl_first;
		mem[word_index(ci_second + `LUA_CI_SAVEDPC_OFS)] = prog_second;
		mem[word_index(prog_second)] = unimpl_second;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		load_command(cmd_load_base, win_base, '0);
		load_command(cmd_load_reg, slot_address(win_base, 0), r0_value);
		load_command(cmd_load_type, slot_address(win_base, 0), r0_tag);
		load_command(cmd_load_reg, slot_address(win_base, 5), r5_value);
		load_command(cmd_load_type, slot_address(win_base, 5), r5_tag);
		// slots 32 and 37 alias onto 0 and 5 without the window check
		load_command(cmd_load_reg, slot_address(win_base, 32), 32'hdead_beef);
		load_command(cmd_load_type, slot_address(win_base, 37), 32'h0000_001f);
		check_word("write count", word_t'(wr_addr_q.size()), 32'd0);

		run_command(cmd_run, ci_first, '0, latency);
		check_word("result", result, unimpl_first);
		check_word("write count", word_t'(wr_addr_q.size()), 32'd5);
		check_write(0, ci_first + `LUA_CI_SAVEDPC_OFS, prog_first + 3 * `LUA_INSTR_BYTES);
		check_write(1, slot_address(win_base, 3), r0_value);
		check_write(2, slot_address(win_base, 3) + `LUA_TTAG_OFS, r0_tag);
		check_write(3, slot_address(win_base, 7), r5_value);
		check_write(4, slot_address(win_base, 7) + `LUA_TTAG_OFS, r5_tag);

		first = wr_addr_q.size();
		run_command(cmd_run, ci_second, '0, latency);
		check_word("result", result, unimpl_second);
		check_word("write count", word_t'(wr_addr_q.size() - first), 32'd1);
		check_write(first, ci_second + `LUA_CI_SAVEDPC_OFS, prog_second + `LUA_INSTR_BYTES);

		repeat (2) @(negedge clk);
		afails = $countones(DUT.u_assert.fail_flags);
		$display("%0d check errors, %0d bound assertion failures", errors, afails);
		if (errors == 0 && afails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#((cmd_count * cmd_cycles + reset_cycles) * clk_period);
		$display("timeout, the command sequence did not finish in time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: list.f
+incdir+include
verilog/lua_cpu_pkg.sv
verilog/pc_unit.sv
verilog/instr_fetch.sv
verilog/instr_exec.sv
verilog/register_file.sv
verilog/register_dumper.sv
verilog/main_sequencer.sv
verilog/lua_cpu.sv
test/lua_cpu_assert.sv
test/lua_cpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the lua_cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f list.f --top-module lua_cpu_tb -o lua_cpu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/lua_cpu_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1
